/* Bender.yml */
package:
  name: miner_uart_link

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/miner_pkg.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/header_collector.sv
      - src/nonce_sender.sv
      - src/display_driver.sv
      - src/miner_uart_link.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/miner_uart_link_assert.sv
      - dv/tb_checker.sv
      - dv/tb_miner_uart_link.sv

/* compile.f */
+incdir+src
src/uart_pkg.sv
src/miner_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/header_collector.sv
src/nonce_sender.sv
src/display_driver.sv
src/miner_uart_link.sv
dv/miner_uart_link_assert.sv
dv/tb_checker.sv
dv/tb_miner_uart_link.sv

/* dv/miner_uart_link_assert.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module miner_uart_link_assert (
    input logic                       clock,
    input logic                       reset,
    input logic                       tx_start,
    input logic                       tx_busy,
    input logic                       txd,
    input logic [`DISPLAY_DIGITS-1:0] an
);

    int assert_failures = 0;

    // A new byte may only be handed over while the transmitter is free.
    start_when_free: assert property (@(posedge clock) disable iff (reset)
        $rose(tx_start) |-> !tx_busy)
        else begin
            assert_failures++;
            $error("tx_start rose while the transmitter was busy");
        end

    line_idle_high: assert property (@(posedge clock) disable iff (reset) !tx_busy |-> txd)
        else begin
            assert_failures++;
            $error("txd was low while the transmitter was not busy");
        end

    // Exactly one anode is driven low at any time.
    one_digit_lit: assert property (@(posedge clock) disable iff (reset) $onehot(~an))
        else begin
            assert_failures++;
            $error("an does not select exactly one digit");
        end

endmodule

bind miner_uart_link miner_uart_link_assert u_link_assert (
    .clock    (clock),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .txd      (txd),
    .an       (an)
);

/* dv/tb_checker.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module tb_checker (
    input logic                       clock,
    input logic                       reset,
    input logic                       txd,
    input miner_pkg::header_t         header,
    input logic                       header_ready,
    input miner_pkg::segment_t        ca,
    input logic [`DISPLAY_DIGITS-1:0] an,
    input miner_pkg::nonce_t          nonce_value
);

    // Standard active-low patterns for 0 to F with the decimal point dark.
    localparam miner_pkg::segment_t SEGMENT_CODES [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    int                         mismatches = 0;
    int                         failures = 0;
    int                         frames_seen = 0;
    uart_pkg::byte_t            expected_bytes[$];
    string                      frame_name = "none";
    string                      display_name = "none";
    logic                       display_on = 1'b0;
    miner_pkg::nonce_t          display_word = '0;
    logic [`DISPLAY_DIGITS-1:0] visited = '0;

    function automatic miner_pkg::hex_digit_t expected_digit(input miner_pkg::nonce_t word,
                                                             input int index);
        return word[4*index +: 4];
    endfunction

    // Bit 4 set means the pattern is no hex digit.
    function automatic logic [4:0] segments_to_hex(input miner_pkg::segment_t segments);
        int i;
        for (i = 0; i < 16; i++) begin
            if (SEGMENT_CODES[i] == segments) begin
                return {1'b0, 4'(i)};
            end
        end
        return 5'h10;
    endfunction

    task automatic expect_nonce(input string name, input miner_pkg::nonce_t value);
        int i;
        frame_name = name;
        for (i = `NONCE_BYTES - 1; i >= 0; i--) begin
            expected_bytes.push_back(value[8*i +: 8]);
        end
    endtask

    task automatic check_header(input string name, input miner_pkg::header_t expected,
                                input logic ready);
        if (header !== expected) begin
            mismatches++;
            $display("MISMATCH %s header: expected %h, actual %h", name, expected, header);
        end
        if (header_ready !== ready) begin
            mismatches++;
            $display("MISMATCH %s header_ready: expected %b, actual %b", name, ready,
                     header_ready);
        end
    endtask

    task automatic check_nonce_value(input string name, input miner_pkg::nonce_t expected);
        if (nonce_value !== expected) begin
            mismatches++;
            $display("MISMATCH %s nonce_value: expected %h, actual %h", name, expected,
                     nonce_value);
        end
    endtask

    task automatic check_line_idle(input string name);
        if (txd !== 1'b1) begin
            mismatches++;
            $display("MISMATCH %s txd: expected 1, actual %b", name, txd);
        end
    endtask

    task automatic start_display(input string name, input miner_pkg::nonce_t word);
        display_name = name;
        display_word = word;
        visited      = '0;
        display_on   = 1'b1;
    endtask

    task automatic stop_display();
        display_on = 1'b0;
        if (visited !== '1) begin
            failures++;
            $display("%s: the scan skipped digits, visited mask %b", display_name, visited);
        end
    endtask

    task automatic check_frames_done();
        if (expected_bytes.size() != 0) begin
            failures++;
            $display("%s: %0d expected frames never appeared on txd", frame_name,
                     expected_bytes.size());
        end
    endtask

    // Samples txd at negative edges, half a clock after the line can change.
    always begin : frame_decoder
        uart_pkg::byte_t data;
        uart_pkg::byte_t expected;
        logic            framing_ok;
        int              i;
        @(negedge clock);
        if (!reset && txd === 1'b0) begin
            repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge clock);
            framing_ok = (txd === 1'b0);
            for (i = 0; i < 8; i++) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clock);
                data[i] = txd;
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clock);
            framing_ok = framing_ok && (txd === 1'b1);
            frames_seen++;
            if (!framing_ok) begin
                failures++;
                $display("%s: frame %0d has a bad start or stop bit", frame_name, frames_seen);
            end
            if (expected_bytes.size() == 0) begin
                failures++;
                $display("%s: frame %0d appeared when no frame was due", frame_name,
                         frames_seen);
            end else begin
                expected = expected_bytes.pop_front();
                if (data !== expected) begin
                    mismatches++;
                    $display("MISMATCH %s frame %0d: expected %h, actual %h", frame_name,
                             frames_seen, expected, data);
                end
            end
        end
    end

    always @(negedge clock) begin : display_monitor
        int         i;
        int         lit;
        int         digit;
        logic [4:0] shown;
        if (display_on) begin
            lit   = 0;
            digit = 0;
            for (i = 0; i < `DISPLAY_DIGITS; i++) begin
                if (an[i] === 1'b0) begin
                    lit++;
                    digit = i;
                end
            end
            shown = segments_to_hex(ca);
            if (lit != 1) begin
                failures++;
                $display("%s: an %b does not light exactly one digit", display_name, an);
            end else if (shown[4]) begin
                failures++;
                $display("%s: digit %0d shows pattern %h, which is no hex digit",
                         display_name, digit, ca);
            end else begin
                visited[digit] = 1'b1;
                if (shown[3:0] !== expected_digit(display_word, digit)) begin
                    mismatches++;
                    $display("MISMATCH %s digit %0d: expected %h, actual %h", display_name,
                             digit, expected_digit(display_word, digit), shown[3:0]);
                end
            end
        end
    end

endmodule

/* dv/tb_miner_uart_link.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

module tb_miner_uart_link;

    localparam int HEADER_W     = `HEADER_BYTES * 8;
    localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
    localparam int SCAN_CYCLES  = `DISPLAY_DIGITS * `DISPLAY_REFRESH_CYCLES;
    // Two headers of 80 frames need 25600 cycles. Two nonce sends with their quiet
    // windows add about 2000 and the display scans a few hundred, so 40000 leaves margin.
    localparam int CYCLE_LIMIT = 40000;

    logic                       clock;
    logic                       reset;
    logic                       rxd;
    miner_pkg::nonce_t          nonce;
    logic                       nonce_we;
    logic                       transmit_data;
    logic                       display_toggle;
    logic                       txd;
    miner_pkg::header_t         header;
    logic                       header_ready;
    miner_pkg::segment_t        ca;
    logic [`DISPLAY_DIGITS-1:0] an;

    integer             seed;
    logic [31:0]        rand_word;
    uart_pkg::byte_t    sent_bytes [2*`HEADER_BYTES];
    int                 sent_count;
    int                 frame_base;
    int                 cycle_count;
    int                 total_errors;
    miner_pkg::nonce_t  expected_nonce;
    miner_pkg::header_t header_value;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    miner_uart_link u_miner_uart_link (
        .clock          (clock),
        .reset          (reset),
        .rxd            (rxd),
        .nonce          (nonce),
        .nonce_we       (nonce_we),
        .transmit_data  (transmit_data),
        .display_toggle (display_toggle),
        .txd            (txd),
        .header         (header),
        .header_ready   (header_ready),
        .ca             (ca),
        .an             (an)
    );

    tb_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .txd          (txd),
        .header       (header),
        .header_ready (header_ready),
        .ca           (ca),
        .an           (an),
        .nonce_value  (u_miner_uart_link.nonce_value)
    );

    // The last 80 bytes sent form the header, the oldest of them in the top byte.
    function automatic miner_pkg::header_t expected_header(input int count);
        miner_pkg::header_t value;
        int                 i;
        value = '0;
        for (i = count - 1; i >= 0 && i >= count - `HEADER_BYTES; i--) begin
            value[8*(count-1-i) +: 8] = sent_bytes[i];
        end
        return value;
    endfunction

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic send_byte(input uart_pkg::byte_t value);
        int i;
        rxd = 1'b0;
        repeat (`UART_CLKS_PER_BIT) step();
        for (i = 0; i < 8; i++) begin
            rxd = value[i];
            repeat (`UART_CLKS_PER_BIT) step();
        end
        rxd = 1'b1;
        repeat (`UART_CLKS_PER_BIT) step();
    endtask

    task automatic send_random_bytes(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            rand_word              = $random(seed);
            sent_bytes[sent_count] = rand_word[7:0];
            send_byte(sent_bytes[sent_count]);
            sent_count++;
        end
    endtask

    task automatic write_nonce(input miner_pkg::nonce_t value);
        nonce    = value;
        nonce_we = 1'b1;
        step();
        nonce_we = 1'b0;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        rxd            = 1'b1;
        nonce          = '0;
        nonce_we       = 1'b0;
        transmit_data  = 1'b0;
        display_toggle = 1'b0;
        seed           = 32'h5791_48d8;
        sent_count     = 0;
        expected_nonce = '0;
        wait (reset === 1'b0);
        step();

        u_checker.check_line_idle("reset_state");
        u_checker.check_header("reset_state", '0, 1'b0);
        u_checker.start_display("reset_display", '0);
        repeat (SCAN_CYCLES + 8) step();
        u_checker.stop_display();

        send_random_bytes(`HEADER_BYTES);
        wait (header_ready === 1'b1);
        step();
        u_checker.check_header("header_first", expected_header(sent_count), 1'b1);
        send_random_bytes(1);
        step();
        u_checker.check_header("header_restart", expected_header(sent_count), 1'b0);
        send_random_bytes(`HEADER_BYTES - 1);
        wait (header_ready === 1'b1);
        step();
        u_checker.check_header("header_second", expected_header(sent_count), 1'b1);

        expected_nonce = $random(seed);
        write_nonce(expected_nonce);
        u_checker.expect_nonce("nonce_send", expected_nonce);
        frame_base    = u_checker.frames_seen;
        transmit_data = 1'b1;
        repeat (2) step();
        transmit_data = 1'b0;
        wait (u_checker.frames_seen == frame_base + `NONCE_BYTES);
        repeat (2 * FRAME_CYCLES) step();

        // Held request, a second rising edge and a nonce write all during one burst.
        expected_nonce = $random(seed);
        write_nonce(expected_nonce);
        u_checker.expect_nonce("nonce_hold", expected_nonce);
        frame_base    = u_checker.frames_seen;
        transmit_data = 1'b1;
        wait (u_checker.frames_seen == frame_base + 1);
        step();
        write_nonce($random(seed));
        u_checker.check_nonce_value("nonce_hold", expected_nonce);
        wait (u_checker.frames_seen == frame_base + 2);
        step();
        transmit_data = 1'b0;
        repeat (2) step();
        transmit_data = 1'b1;
        wait (u_checker.frames_seen == frame_base + `NONCE_BYTES);
        repeat (2 * FRAME_CYCLES) step();
        u_checker.check_nonce_value("nonce_hold", expected_nonce);
        transmit_data = 1'b0;
        step();

        u_checker.start_display("display_nonce", expected_nonce);
        repeat (SCAN_CYCLES + 8) step();
        u_checker.stop_display();
        display_toggle = 1'b1;
        step();
        header_value = expected_header(sent_count);
        u_checker.start_display("display_header", header_value[HEADER_W-1 -: 32]);
        repeat (SCAN_CYCLES + 8) step();
        u_checker.stop_display();

        u_checker.check_frames_done();
        total_errors = u_checker.mismatches + u_checker.failures
                     + u_miner_uart_link.u_link_assert.assert_failures;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 u_checker.mismatches, u_checker.failures,
                 u_miner_uart_link.u_link_assert.assert_failures);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src/display_driver.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module display_driver (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        display_toggle,
    input  miner_pkg::nonce_t           header_word,
    input  miner_pkg::nonce_t           nonce_value,
    output miner_pkg::segment_t         ca,
    output logic [`DISPLAY_DIGITS-1:0]  an
);

    localparam int REFRESH_W = $clog2(`DISPLAY_REFRESH_CYCLES);
    localparam int DIGIT_W   = $clog2(`DISPLAY_DIGITS);
    localparam logic [REFRESH_W-1:0] REFRESH_LAST = REFRESH_W'(`DISPLAY_REFRESH_CYCLES - 1);

    logic [REFRESH_W-1:0]       refresh_count;
    logic [DIGIT_W-1:0]         digit_index;
    miner_pkg::nonce_t          shown;
    miner_pkg::hex_digit_t      nibble;
    logic [`DISPLAY_DIGITS-1:0] an_next;

    function automatic miner_pkg::segment_t hex_to_segments(input miner_pkg::hex_digit_t value);
        case (value)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    assign shown  = display_toggle ? header_word : nonce_value;
    assign nibble = miner_pkg::hex_digit_t'(shown >> (4 * digit_index));

    always_comb begin
        an_next              = '1;
        an_next[digit_index] = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            refresh_count <= '0;
            digit_index   <= '0;
        end else if (refresh_count == REFRESH_LAST) begin
            refresh_count <= '0;
            digit_index   <= digit_index + DIGIT_W'(1);
        end else begin
            refresh_count <= refresh_count + REFRESH_W'(1);
        end
    end

    // Anode and cathode are registered together so they stay aligned.
    always_ff @(posedge clock) begin
        an <= an_next;
        ca <= hex_to_segments(nibble);
    end

endmodule

/* src/header_collector.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module header_collector (
    input  logic              clock,
    input  logic              reset,
    input  logic              rx_valid,
    input  uart_pkg::byte_t   rx_byte,
    output miner_pkg::header_t header,
    output logic              header_ready
);

    localparam miner_pkg::byte_count_t LAST_COUNT = miner_pkg::byte_count_t'(`HEADER_BYTES);

    miner_pkg::byte_count_t byte_count;

    // Each byte enters at the low end, so the first byte ends up on top.
    always_ff @(posedge clock) begin
        if (reset) begin
            header <= '0;
        end else if (rx_valid) begin
            header <= {header[`HEADER_BYTES*8-9:0], rx_byte};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count   <= '0;
            header_ready <= 1'b0;
        end else if (rx_valid) begin
            // A byte after a complete header starts the next one.
            if (byte_count == LAST_COUNT) begin
                byte_count <= miner_pkg::byte_count_t'(1);
            end else begin
                byte_count <= byte_count + 7'd1;
            end
            header_ready <= (byte_count == LAST_COUNT - 7'd1);
        end
    end

endmodule

/* src/miner_params.svh */
`ifndef MINER_PARAMS_SVH
`define MINER_PARAMS_SVH

// Clock cycles per serial bit. A short value keeps simulation fast.
`define UART_CLKS_PER_BIT 16

// Bytes in one block header received over the serial line.
`define HEADER_BYTES 80

// Bytes in one nonce sent back over the serial line.
`define NONCE_BYTES 4

// Digits on the seven-segment display.
`define DISPLAY_DIGITS 8

// Clock cycles each digit stays lit before the scan moves on.
`define DISPLAY_REFRESH_CYCLES 8

`endif

/* src/miner_pkg.sv */
`include "miner_params.svh"

package miner_pkg;

    typedef logic [`HEADER_BYTES*8-1:0] header_t;
    typedef logic [`NONCE_BYTES*8-1:0] nonce_t;

    // Counts up to HEADER_BYTES.
    typedef logic [6:0] byte_count_t;

    typedef logic [3:0] hex_digit_t;

    // Active-low cathodes. Bits 0 to 6 drive segments a to g, bit 7 the decimal point.
    typedef logic [7:0] segment_t;

    typedef enum logic [1:0] {
        send_idle,
        send_start,
        send_wait_busy,
        send_wait_done
    } sender_state_t;

endpackage

/* src/miner_uart_link.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module miner_uart_link (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       rxd,
    input  miner_pkg::nonce_t          nonce,
    input  logic                       nonce_we,
    input  logic                       transmit_data,
    input  logic                       display_toggle,
    output logic                       txd,
    output miner_pkg::header_t         header,
    output logic                       header_ready,
    output miner_pkg::segment_t        ca,
    output logic [`DISPLAY_DIGITS-1:0] an
);

    uart_pkg::byte_t   rx_byte;
    logic              rx_valid;
    uart_pkg::byte_t   tx_byte;
    logic              tx_start;
    logic              tx_busy;
    miner_pkg::nonce_t nonce_value;

    uart_rx u_uart_rx (
        .clock    (clock),
        .reset    (reset),
        .rxd      (rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    header_collector u_header_collector (
        .clock        (clock),
        .reset        (reset),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .header       (header),
        .header_ready (header_ready)
    );

    nonce_sender u_nonce_sender (
        .clock         (clock),
        .reset         (reset),
        .nonce_we      (nonce_we),
        .transmit_data (transmit_data),
        .tx_busy       (tx_busy),
        .nonce         (nonce),
        .tx_byte       (tx_byte),
        .tx_start      (tx_start),
        .nonce_value   (nonce_value)
    );

    uart_tx u_uart_tx (
        .clock    (clock),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    // The display shows the top word of the header, the first four bytes received.
    display_driver u_display_driver (
        .clock          (clock),
        .reset          (reset),
        .display_toggle (display_toggle),
        .header_word    (header[`HEADER_BYTES*8-1 -: `NONCE_BYTES*8]),
        .nonce_value    (nonce_value),
        .ca             (ca),
        .an             (an)
    );

endmodule

/* src/nonce_sender.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module nonce_sender (
    input  logic              clock,
    input  logic              reset,
    input  logic              nonce_we,
    input  logic              transmit_data,
    input  logic              tx_busy,
    input  miner_pkg::nonce_t nonce,
    output uart_pkg::byte_t   tx_byte,
    output logic              tx_start,
    output miner_pkg::nonce_t nonce_value
);

    localparam int INDEX_W = $clog2(`NONCE_BYTES);
    localparam logic [INDEX_W-1:0] LAST_INDEX = INDEX_W'(`NONCE_BYTES - 1);

    miner_pkg::sender_state_t state;
    miner_pkg::nonce_t        nonce_reg;
    logic [INDEX_W-1:0]       byte_index;
    logic                     transmit_prev;
    logic                     transmit_rise;

    assign transmit_rise = transmit_data && !transmit_prev;

    always_ff @(posedge clock) begin
        if (reset) begin
            transmit_prev <= 1'b0;
            nonce_reg     <= '0;
        end else begin
            transmit_prev <= transmit_data;
            // The nonce is frozen while a send is under way.
            if (nonce_we && state == miner_pkg::send_idle) begin
                nonce_reg <= nonce;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= miner_pkg::send_idle;
            byte_index <= '0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                miner_pkg::send_idle: begin
                    byte_index <= '0;
                    if (transmit_rise) begin
                        state <= miner_pkg::send_start;
                    end
                end
                miner_pkg::send_start: begin
                    tx_start <= 1'b1;
                    state    <= miner_pkg::send_wait_busy;
                end
                miner_pkg::send_wait_busy: begin
                    if (tx_busy) begin
                        state <= miner_pkg::send_wait_done;
                    end
                end
                default: begin
                    if (!tx_busy) begin
                        byte_index <= byte_index + INDEX_W'(1);
                        state      <= (byte_index == LAST_INDEX) ? miner_pkg::send_idle
                                                                 : miner_pkg::send_start;
                    end
                end
            endcase
        end
    end

    // Most significant byte goes out first.
    assign tx_byte     = uart_pkg::byte_t'(nonce_reg >> (8 * (LAST_INDEX - byte_index)));
    assign nonce_value = nonce_reg;

endmodule

/* src/uart_pkg.sv */
`include "miner_params.svh"

package uart_pkg;

    typedef logic [7:0] byte_t;

    // Wide enough for any bit period used on the board.
    typedef logic [7:0] baud_count_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module uart_rx (
    input  logic             clock,
    input  logic             reset,
    input  logic             rxd,
    output uart_pkg::byte_t  rx_byte,
    output logic             rx_valid
);

    localparam uart_pkg::baud_count_t BIT_LAST  = uart_pkg::baud_count_t'(`UART_CLKS_PER_BIT - 1);
    localparam uart_pkg::baud_count_t HALF_LAST =
        uart_pkg::baud_count_t'(`UART_CLKS_PER_BIT / 2 - 1);

    uart_pkg::rx_state_t   state;
    uart_pkg::baud_count_t baud_count;
    logic [2:0]            bit_index;
    logic                  rxd_meta;
    logic                  rxd_sync;
    uart_pkg::byte_t       shift;

    // The line idles high, so the synchronizer resets to one.
    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= uart_pkg::rx_idle;
            baud_count <= '0;
            bit_index  <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                uart_pkg::rx_idle: begin
                    baud_count <= '0;
                    if (!rxd_sync) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    // A glitch shorter than half a bit returns to idle.
                    if (baud_count == HALF_LAST) begin
                        baud_count <= '0;
                        bit_index  <= '0;
                        state      <= rxd_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
                    end else begin
                        baud_count <= baud_count + 8'd1;
                    end
                end
                uart_pkg::rx_data: begin
                    if (baud_count == BIT_LAST) begin
                        baud_count <= '0;
                        shift      <= {rxd_sync, shift[7:1]};
                        if (bit_index == 3'd7) begin
                            state <= uart_pkg::rx_stop;
                        end
                        bit_index <= bit_index + 3'd1;
                    end else begin
                        baud_count <= baud_count + 8'd1;
                    end
                end
                default: begin
                    if (baud_count == BIT_LAST) begin
                        baud_count <= '0;
                        rx_valid   <= rxd_sync;
                        state      <= uart_pkg::rx_idle;
                    end else begin
                        baud_count <= baud_count + 8'd1;
                    end
                end
            endcase
        end
    end

    assign rx_byte = shift;

endmodule

/* src/uart_tx.sv */
`timescale 1ns/10ps
`include "miner_params.svh"

module uart_tx (
    input  logic            clock,
    input  logic            reset,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_byte,
    output logic            txd,
    output logic            tx_busy
);

    localparam uart_pkg::baud_count_t BIT_LAST = uart_pkg::baud_count_t'(`UART_CLKS_PER_BIT - 1);

    uart_pkg::tx_state_t   state;
    uart_pkg::baud_count_t baud_count;
    logic [2:0]            bit_index;
    uart_pkg::byte_t       shift;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= uart_pkg::tx_idle;
            baud_count <= '0;
            bit_index  <= '0;
            txd        <= 1'b1;
            tx_busy    <= 1'b0;
        end else begin
            baud_count <= baud_count + 8'd1;
            case (state)
                uart_pkg::tx_idle: begin
                    txd        <= 1'b1;
                    tx_busy    <= 1'b0;
                    baud_count <= '0;
                    if (tx_start) begin
                        shift   <= tx_byte;
                        txd     <= 1'b0;
                        tx_busy <= 1'b1;
                        state   <= uart_pkg::tx_start;
                    end
                end
                uart_pkg::tx_start: begin
                    if (baud_count == BIT_LAST) begin
                        baud_count <= '0;
                        bit_index  <= '0;
                        txd        <= shift[0];
                        state      <= uart_pkg::tx_data;
                    end
                end
                uart_pkg::tx_data: begin
                    if (baud_count == BIT_LAST) begin
                        baud_count <= '0;
                        shift      <= shift >> 1;
                        bit_index  <= bit_index + 3'd1;
                        txd        <= (bit_index == 3'd7) ? 1'b1 : shift[1];
                        if (bit_index == 3'd7) begin
                            state <= uart_pkg::tx_stop;
                        end
                    end
                end
                default: begin
                    // Busy drops as the stop bit ends.
                    if (baud_count == BIT_LAST) begin
                        tx_busy <= 1'b0;
                        state   <= uart_pkg::tx_idle;
                    end
                end
            endcase
        end
    end

endmodule
